// ==== flist.f ====
+incdir+include
rtl/periph_pkg.sv
rtl/periph_bus_ctrl.sv
rtl/periph_addr_decode.sv
rtl/gpio_pin_ctrl.sv
rtl/edge_counter.sv
rtl/periph_top.sv
tb/tb_periph_top.sv

// ==== include/tb_bus_tasks.svh ====
/*
 * Testbench bus tasks
 * Word write, read with bounded wait for ready and a hold check,
 * and a compare task that counts checks and errors.
 */

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

task automatic bus_write(input logic [10:0] addr, input logic [31:0] data);
    @(posedge clk);
    bus_addr    <= addr;
    bus_wdata   <= data;
    bus_write_n <= 2'b10;
    @(posedge clk);
    bus_write_n <= 2'b11;
endtask

// Latency counts clock edges from request to ready
task automatic bus_read(input logic [10:0] addr, input int hold,
                        output logic [31:0] data, output int lat);
    lat = 0;
    @(posedge clk);
    bus_addr   <= addr;
    bus_read_n <= 2'b10;
    @(negedge clk);
    while (!bus_ready && lat < bus_timeout_cycles) begin
        @(negedge clk);
        lat++;
    end
    if (!bus_ready) begin
        err_cnt++;
        $display("  timeout reading %h", addr);
    end
    data = bus_rdata;
    // Ready and data must stay put until complete
    repeat (hold) begin
        @(negedge clk);
        if (!bus_ready || bus_rdata !== data) begin
            err_cnt++;
            $display("  hold lost reading %h", addr);
        end
    end
    @(posedge clk);
    bus_read_n        <= 2'b11;
    bus_read_complete <= 1'b1;
    @(posedge clk);
    bus_read_complete <= 1'b0;
endtask

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("FAIL %0t %s got %h exp %h", $time, name, got, exp);
    end
endtask

`endif

// ==== tb/tb_periph_top.sv ====
/*
 * Testbench for the peripheral wrapper
 * Random bus traffic and pin stimulus, checked against a model of the
 * GPIO registers, function selects and the rising edge counter.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_periph_top
    import periph_pkg::*;
();

    logic              clk;
    logic              rst_n;
    logic [pins_w-1:0] ui_in;
    logic [pins_w-1:0] uo_out;
    logic [addr_w-1:0] bus_addr;
    logic [data_w-1:0] bus_wdata;
    logic [1:0]        bus_write_n;
    logic [1:0]        bus_read_n;
    logic [data_w-1:0] bus_rdata;
    logic              bus_ready;
    logic              bus_read_complete;
    int                err_cnt;
    int                chk_cnt;
    integer            seed;

    // Model state
    logic [7:0]            m_gpio_out;
    logic [func_sel_w-1:0] m_func [pins_w];
    logic [7:0]            m_count;
    logic [2:0]            m_pin_sel;
    logic [pins_w-1:0]     m_prev_ui;
    logic                  m_wr_gpio;
    logic                  m_wr_cnt;

    periph_top DUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (bus_addr),
        .i_data               (bus_wdata),
        .i_data_write_n       (bus_write_n),
        .i_data_read_n        (bus_read_n),
        .o_data               (bus_rdata),
        .o_data_ready         (bus_ready),
        .i_data_read_complete (bus_read_complete)
    );

    `include "tb_bus_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // User slot sits in bits 9:6 and simple slot in bits 7:4
    assign m_wr_gpio = (bus_write_n != 2'b11) && !bus_addr[10] && (bus_addr[9:6] == slot_gpio);
    assign m_wr_cnt  = (bus_write_n != 2'b11) && bus_addr[10] && (bus_addr[7:4] == slot_edge_cnt);

    always @(posedge clk) begin
        m_prev_ui <= ui_in;
        if (!rst_n) begin
            m_gpio_out <= '0;
            for (int i = 0; i < pins_w; i++) begin
                m_func[i] <= {1'b0, slot_gpio};
            end
            m_count   <= '0;
            m_pin_sel <= '0;
        end else begin
            if (m_wr_gpio && bus_addr[5:0] == gpio_off_out) begin
                m_gpio_out <= bus_wdata[7:0];
            end
            if (m_wr_gpio && bus_addr[5] && bus_addr[1:0] == 2'b00) begin
                m_func[bus_addr[4:2]] <= bus_wdata[func_sel_w-1:0];
            end
            if (m_wr_cnt && bus_addr[3:0] == cnt_off_count) begin
                m_count <= bus_wdata[7:0];
            end else if (ui_in[m_pin_sel] && !m_prev_ui[m_pin_sel]) begin
                m_count <= m_count + 8'd1;
            end
            if (m_wr_cnt && bus_addr[3:0] == cnt_off_pin) begin
                m_pin_sel <= bus_wdata[2:0];
            end
        end
    end

    function automatic logic [addr_w-1:0] user_addr(input logic [3:0] slot,
                                                    input logic [5:0] off);
        return {1'b0, slot, off};
    endfunction

    function automatic logic [addr_w-1:0] simple_addr(input logic [3:0] slot,
                                                      input logic [3:0] off);
        return {1'b1, 2'b00, slot, off};
    endfunction

    // Each pin follows the source its select names or stays low
    function automatic logic [pins_w-1:0] expected_pins();
        logic [pins_w-1:0] pins;
        pins = '0;
        for (int i = 0; i < pins_w; i++) begin
            if (m_func[i] == {1'b0, slot_gpio}) begin
                pins[i] = m_gpio_out[i];
            end else if (m_func[i] == {1'b1, slot_edge_cnt}) begin
                pins[i] = m_count[i];
            end
        end
        return pins;
    endfunction

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic check_unmapped_read(input logic [addr_w-1:0] addr);
        logic [31:0] rdata;
        int          lat;
        bus_read(addr, 3, rdata, lat);
        check_eq("unmapped data", rdata, 32'h0);
        check_eq("read latency", lat, 1);
        @(negedge clk);
        check_eq("ready after complete", bus_ready, 1'b0);
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [31:0] pick;
        logic [4:0]  sel;
        int          lat;
        int          errs_before;
        seed              = 32'h79a2efe1;
        err_cnt           = 0;
        chk_cnt           = 0;
        rst_n             = 1'b0;
        ui_in             = '0;
        bus_addr          = '0;
        bus_wdata         = '0;
        bus_write_n       = 2'b11;
        bus_read_n        = 2'b11;
        bus_read_complete = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        errs_before = err_cnt;
        bus_read(user_addr(slot_gpio, gpio_off_out), 1, rdata, lat);
        check_eq("gpio out", rdata, 32'h0);
        check_eq("read latency", lat, 1);
        for (int i = 0; i < pins_w; i++) begin
            bus_read(user_addr(slot_gpio, gpio_off_func + 6'(i * 4)), 0, rdata, lat);
            check_eq("func select", rdata, {27'b0, 1'b0, slot_gpio});
        end
        bus_read(simple_addr(slot_edge_cnt, cnt_off_count), 0, rdata, lat);
        check_eq("count", rdata, 32'h0);
        bus_read(simple_addr(slot_edge_cnt, cnt_off_pin), 0, rdata, lat);
        check_eq("pin select", rdata, 32'h0);
        @(negedge clk);
        check_eq("pins out", uo_out, 32'h0);
        report_test("reset values", errs_before);

        errs_before = err_cnt;
        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
            ui_in <= $random(seed);
            wdata = $random(seed);
            bus_write(user_addr(slot_gpio, gpio_off_out), wdata);
            bus_read(user_addr(slot_gpio, gpio_off_out), 0, rdata, lat);
            @(negedge clk);
            check_eq("gpio out readback", rdata, {24'b0, m_gpio_out});
            bus_read(user_addr(slot_gpio, gpio_off_in), 0, rdata, lat);
            check_eq("input pins", rdata, {24'b0, ui_in});
            @(negedge clk);
            check_eq("pins out", uo_out, expected_pins());
        end
        report_test("gpio out and inputs", errs_before);

        errs_before = err_cnt;
        for (int n = 0; n < 4; n++) begin
            for (int p = 0; p < pins_w; p++) begin
                pick = $random(seed);
                case (pick[1:0])
                    2'd0:    sel = {1'b0, slot_gpio};
                    2'd1:    sel = {1'b1, slot_edge_cnt};
                    default: sel = pick[8:4];
                endcase
                bus_write(user_addr(slot_gpio, gpio_off_func + 6'(p * 4)), {27'b0, sel});
            end
            bus_write(user_addr(slot_gpio, gpio_off_out), $random(seed));
            bus_write(simple_addr(slot_edge_cnt, cnt_off_count), $random(seed));
            bus_read(user_addr(slot_gpio, gpio_off_func + 6'(pick[2:0] * 4)), 0, rdata, lat);
            @(negedge clk);
            check_eq("func readback", rdata, {27'b0, m_func[pick[2:0]]});
            check_eq("pins out", uo_out, expected_pins());
        end
        report_test("pin function select", errs_before);

        errs_before = err_cnt;
        for (int n = 0; n < 4; n++) begin
            bus_write(simple_addr(slot_edge_cnt, cnt_off_pin), $random(seed));
            repeat (20) begin
                @(posedge clk);
                ui_in <= $random(seed);
            end
            repeat (2) @(posedge clk);
            bus_read(simple_addr(slot_edge_cnt, cnt_off_count), 0, rdata, lat);
            @(negedge clk);
            check_eq("edge count", rdata, {24'b0, m_count});
            bus_read(simple_addr(slot_edge_cnt, cnt_off_pin), 0, rdata, lat);
            check_eq("pin select", rdata, {29'b0, m_pin_sel});
            bus_write(simple_addr(slot_edge_cnt, cnt_off_count), $random(seed));
            bus_read(simple_addr(slot_edge_cnt, cnt_off_count), 0, rdata, lat);
            @(negedge clk);
            check_eq("count load", rdata, {24'b0, m_count});
        end
        report_test("edge counter", errs_before);

        errs_before = err_cnt;
        check_unmapped_read(user_addr(4'd0, 6'h00));
        check_unmapped_read(user_addr(4'd5, 6'h00));
        check_unmapped_read(user_addr(4'd15, 6'h3f));
        check_unmapped_read(simple_addr(4'd0, 4'h0));
        check_unmapped_read(simple_addr(4'd9, 4'h1));
        check_unmapped_read(user_addr(slot_gpio, 6'h08));
        check_unmapped_read(user_addr(slot_gpio, 6'h22));
        check_unmapped_read(simple_addr(slot_edge_cnt, 4'h2));
        // Inputs change while the read is held, so the captured word must not follow
        @(posedge clk);
        ui_in <= 8'h5a;
        fork
            bus_read(user_addr(slot_gpio, gpio_off_in), 3, rdata, lat);
            begin
                repeat (3) @(posedge clk);
                ui_in <= 8'ha5;
            end
        join
        check_eq("held input pins", rdata, 32'h5a);
        check_eq("read latency", lat, 1);
        report_test("unmapped reads and hold", errs_before);

        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/periph_top.sv ====
/*
 * Peripheral wrapper top level
 * Connects the bus controller, address decoder, GPIO pin block and
 * the edge counter to the core bus and the pins.
 */

`timescale 1ns/1ps
`default_nettype none

module periph_top
    import periph_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [pins_w-1:0] i_ui_in,
    output wire logic [pins_w-1:0] o_uo_out,
    input  wire logic [addr_w-1:0] i_addr,
    input  wire logic [data_w-1:0] i_data,
    input  wire logic [1:0]        i_data_write_n,
    input  wire logic [1:0]        i_data_read_n,
    output wire logic [data_w-1:0] o_data,
    output wire logic              o_data_ready,
    input  wire logic              i_data_read_complete
);

    periph_addr_u      addr_view;
    logic              write_req;
    logic              gpio_wr;
    logic              cnt_wr;
    logic [data_w-1:0] periph_data;
    logic              periph_ready;
    logic [data_w-1:0] gpio_rdata;
    logic [7:0]        cnt_rdata;
    logic [pins_w-1:0] cnt_pins;

    assign addr_view = i_addr;

    periph_bus_ctrl u_bus_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .i_periph_data        (periph_data),
        .i_periph_ready       (periph_ready),
        .o_write_req          (write_req),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready)
    );

    periph_addr_decode u_decode (
        .i_addr         (addr_view),
        .i_write_req    (write_req),
        .i_gpio_rdata   (gpio_rdata),
        .i_cnt_rdata    (cnt_rdata),
        .o_gpio_wr      (gpio_wr),
        .o_cnt_wr       (cnt_wr),
        .o_periph_data  (periph_data),
        .o_periph_ready (periph_ready)
    );

    gpio_pin_ctrl u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr       (gpio_wr),
        .i_offset   (addr_view.user.offset),
        .i_wdata    (i_data[7:0]),
        .i_ui_in    (i_ui_in),
        .i_cnt_pins (cnt_pins),
        .o_rdata    (gpio_rdata),
        .o_uo_out   (o_uo_out)
    );

    edge_counter u_edge_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wr     (cnt_wr),
        .i_offset (addr_view.simple.offset),
        .i_wdata  (i_data[7:0]),
        .i_ui_in  (i_ui_in),
        .o_rdata  (cnt_rdata),
        .o_uo_out (cnt_pins)
    );

endmodule

`default_nettype wire

// ==== rtl/edge_counter.sv ====
/*
 * Rising edge counter
 * Byte peripheral counting rising edges on one selectable input pin.
 * The count is also presented on the pin outputs.
 */

`timescale 1ns/1ps
`default_nettype none

module edge_counter
    import periph_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              i_wr,
    input  wire logic [3:0]        i_offset,
    input  wire logic [7:0]        i_wdata,
    input  wire logic [pins_w-1:0] i_ui_in,
    output logic [7:0]             o_rdata,
    output logic [pins_w-1:0]      o_uo_out
);

    logic [pins_w-1:0] ui_prev_q;
    logic [7:0]        count_q;
    logic [2:0]        pin_sel_q;
    logic              rise;

    // Sampled during reset too, so no edge is seen on release
    always_ff @(posedge clk) begin
        ui_prev_q <= i_ui_in;
    end

    assign rise = i_ui_in[pin_sel_q] && !ui_prev_q[pin_sel_q];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q   <= '0;
            pin_sel_q <= '0;
        end else begin
            // Load wins over a same-cycle edge
            if (i_wr && (i_offset == cnt_off_count)) begin
                count_q <= i_wdata;
            end else if (rise) begin
                count_q <= count_q + 8'd1;
            end
            if (i_wr && (i_offset == cnt_off_pin)) begin
                pin_sel_q <= i_wdata[2:0];
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_offset == cnt_off_count) begin
            o_rdata = count_q;
        end else if (i_offset == cnt_off_pin) begin
            o_rdata = {5'b0, pin_sel_q};
        end
    end

    assign o_uo_out = count_q;

endmodule

`default_nettype wire

// ==== rtl/gpio_pin_ctrl.sv ====
/*
 * GPIO and pin control
 * Output register, per-pin function select and the output pin mux
 * that routes each pin from GPIO or the edge counter.
 */

`timescale 1ns/1ps
`default_nettype none

module gpio_pin_ctrl
    import periph_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              i_wr,
    input  wire logic [5:0]        i_offset,
    input  wire logic [7:0]        i_wdata,
    input  wire logic [pins_w-1:0] i_ui_in,
    input  wire logic [pins_w-1:0] i_cnt_pins,
    output logic [data_w-1:0]      o_rdata,
    output logic [pins_w-1:0]      o_uo_out
);

    logic [pins_w-1:0]     gpio_out_q;
    logic [func_sel_w-1:0] func_sel_q [pins_w];
    logic                  func_hit;
    logic [2:0]            func_idx;

    // Function select words sit at 0x20..0x3c, one per pin
    assign func_hit = (i_offset >= gpio_off_func) && (i_offset[1:0] == 2'b00);
    assign func_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
            for (int i = 0; i < pins_w; i++) begin
                func_sel_q[i] <= func_sel_reset;
            end
        end else if (i_wr) begin
            if (i_offset == gpio_off_out) begin
                gpio_out_q <= i_wdata;
            end
            if (func_hit) begin
                func_sel_q[func_idx] <= i_wdata[func_sel_w-1:0];
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_offset == gpio_off_out) begin
            o_rdata[pins_w-1:0] = gpio_out_q;
        end else if (i_offset == gpio_off_in) begin
            o_rdata[pins_w-1:0] = i_ui_in;
        end else if (func_hit) begin
            o_rdata[func_sel_w-1:0] = func_sel_q[func_idx];
        end
    end

    // Top select bit picks the simple region, low bits the slot
    always_comb begin
        for (int i = 0; i < pins_w; i++) begin
            if (func_sel_q[i] == {1'b0, slot_gpio}) begin
                o_uo_out[i] = gpio_out_q[i];
            end else if (func_sel_q[i] == {1'b1, slot_edge_cnt}) begin
                o_uo_out[i] = i_cnt_pins[i];
            end else begin
                o_uo_out[i] = 1'b0;
            end
        end
    end

    for (genvar g = 0; g < pins_w; g++) begin : g_sel_chk
        assert property (@(posedge clk)
            $rose(rst_n) |-> (func_sel_q[g] == func_sel_reset));
    end

endmodule

`default_nettype wire

// ==== rtl/periph_addr_decode.sv ====
/*
 * Peripheral address decoder
 * Picks the user or simple view of the address, forms the write
 * strobes and muxes read data back from the selected slot.
 */

`timescale 1ns/1ps
`default_nettype none

module periph_addr_decode
    import periph_pkg::*;
(
    input  wire periph_addr_u      i_addr,
    input  wire logic              i_write_req,
    input  wire logic [data_w-1:0] i_gpio_rdata,
    input  wire logic [7:0]        i_cnt_rdata,
    output logic                   o_gpio_wr,
    output logic                   o_cnt_wr,
    output logic [data_w-1:0]      o_periph_data,
    output logic                   o_periph_ready
);

    logic is_simple;
    logic gpio_sel;
    logic cnt_sel;

    assign is_simple = i_addr.user.region;

    // Region bit decides which view of the slot field is valid
    assign gpio_sel = !is_simple && (i_addr.user.slot == slot_gpio);
    assign cnt_sel  = is_simple && (i_addr.simple.slot == slot_edge_cnt);

    assign o_gpio_wr = i_write_req && gpio_sel;
    assign o_cnt_wr  = i_write_req && cnt_sel;

    // Unmapped slots read as zero
    always_comb begin
        o_periph_data = '0;
        if (gpio_sel) begin
            o_periph_data = i_gpio_rdata;
        end else if (cnt_sel) begin
            o_periph_data = {{(data_w-8){1'b0}}, i_cnt_rdata};
        end
    end

    // Every kept peripheral answers immediately
    assign o_periph_ready = 1'b1;

endmodule

`default_nettype wire

// ==== rtl/periph_bus_ctrl.sv ====
/*
 * Peripheral bus controller
 * Turns the core's size codes into requests, registers the read data
 * and holds it until the core signals read complete.
 */

`timescale 1ns/1ps
`default_nettype none

module periph_bus_ctrl
    import periph_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [1:0]        i_data_write_n,
    input  wire logic [1:0]        i_data_read_n,
    input  wire logic              i_data_read_complete,
    input  wire logic [data_w-1:0] i_periph_data,
    input  wire logic              i_periph_ready,
    output logic                   o_write_req,
    output logic [data_w-1:0]      o_data,
    output logic                   o_data_ready
);

    logic              read_req;
    logic              capture;
    // Idle when clear and hold when set
    logic              hold_q;
    logic              ready_q;
    logic [data_w-1:0] data_q;

    assign read_req    = (i_data_read_n != 2'b11);
    assign o_write_req = (i_data_write_n != 2'b11);
    assign capture     = !hold_q && read_req && i_periph_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && i_periph_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_periph_data;
        end
    end

    assign o_data       = data_q;
    // Writes complete in the cycle they are requested
    assign o_data_ready = (ready_q && read_req) || o_write_req;

    // A read is acknowledged only while its captured data is held
    assert property (@(posedge clk) disable iff (!rst_n)
        (o_data_ready && !o_write_req) |-> (read_req && hold_q));

    assert property (@(posedge clk) disable iff (!rst_n)
        hold_q |=> $stable(o_data));

endmodule

`default_nettype wire

// ==== rtl/periph_pkg.sv ====
/*
 * Peripheral bus definitions
 * Address layout of the user and simple regions, slot numbers,
 * register offsets and the two views of the peripheral address.
 */

`default_nettype none

package periph_pkg;

    // Bus widths
    localparam int addr_w     = 11;
    localparam int data_w     = 32;
    localparam int pins_w     = 8;
    localparam int func_sel_w = 5;

    // Slot numbers within each region
    localparam logic [3:0] slot_gpio     = 4'd1;
    localparam logic [3:0] slot_edge_cnt = 4'd1;

    // GPIO register offsets, function selects are one word per pin
    localparam logic [5:0] gpio_off_out  = 6'h00;
    localparam logic [5:0] gpio_off_in   = 6'h04;
    localparam logic [5:0] gpio_off_func = 6'h20;

    // Edge counter byte offsets
    localparam logic [3:0] cnt_off_count = 4'd0;
    localparam logic [3:0] cnt_off_pin   = 4'd1;

    // Pins come out of reset driven by GPIO
    localparam logic [func_sel_w-1:0] func_sel_reset = {1'b0, slot_gpio};

    // Testbench wait limit for ready, in cycles
    localparam int bus_timeout_cycles = 16;

    // Region bit set selects the simple (byte) peripherals
    typedef union packed {
        struct packed {
            logic       region;
            logic [3:0] slot;
            logic [5:0] offset;
        } user;
        struct packed {
            logic       region;
            logic [1:0] unused;
            logic [3:0] slot;
            logic [3:0] offset;
        } simple;
    } periph_addr_u;

endpackage

`default_nettype wire
